// ==== design/spi_link_pkg.sv ====
// SPI link definitions.
// Word size and the bit counter that walks through one word.
`default_nettype none

package spi_link_pkg;

    ////////////////////
    // Word format
    ////////////////////

    // Bits per SPI word, sent MSB first.
    localparam int WORD_W = 8;

    // One SPI word as it sits in a FIFO or a shift register.
    typedef logic [WORD_W-1:0] word_t;

    ////////////////////
    // Bit counting
    ////////////////////

    // Counter that indexes the bits of one word.
    // It wraps at the word boundary, so WORD_W stays a power of two.
    localparam int BIT_CNT_W = $clog2(WORD_W);

endpackage

`default_nettype wire

// ==== design/wb_regs_pkg.sv ====
// Wishbone register map of the SPI sub peripheral.
// Bus widths, register addresses and STATUS bit positions.
`default_nettype none

package wb_regs_pkg;

    ////////////////////
    // Bus widths
    ////////////////////

    // Word address, four registers.
    localparam int WB_ADR_W = 2;
    // Data bus width.
    localparam int WB_DAT_W = 32;

    ////////////////////
    // Register map
    ////////////////////

    typedef enum logic [WB_ADR_W-1:0] {
        REG_CTRL   = 2'd0,  // Fill byte in bits 7:0.
        REG_STATUS = 2'd1,  // Flags, write 1 to clear frame done.
        REG_TXDATA = 2'd2,  // Write pushes a transmit word.
        REG_RXDATA = 2'd3   // Read pops a receive word.
    } reg_addr_e;

    // STATUS bit positions.
    localparam int STAT_RX_READY   = 0;
    localparam int STAT_TX_READY   = 1;
    localparam int STAT_ACTIVE     = 2;
    localparam int STAT_FRAME_DONE = 3;

endpackage

`default_nettype wire

// ==== design/async_fifo.sv ====
// Dual-clock FIFO.
// Gray-coded pointers cross the domains through two-flop synchronizers.
// The head word is shown on data_out while rd_ready is high.
`default_nettype none

module async_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  wire              arst_n,

    // Write side.
    input  wire              wr_clk,
    input  wire              wr_en,
    input  wire [WIDTH-1:0]  data_in,
    output logic             wr_ready,

    // Read side.
    input  wire              rd_clk,
    input  wire              rd_en,
    output logic [WIDTH-1:0] data_out,
    output logic             rd_ready
);
    // Address width, DEPTH is a power of two and at least 2.
    localparam int AW = $clog2(DEPTH);
    // Full when the top two Gray bits differ and the rest match.
    localparam logic [AW:0] FULL_XOR = (AW + 1)'(3) << (AW - 1);

    // Storage.
    logic [WIDTH-1:0] mem [DEPTH];

    // Pointers carry one extra bit to tell full from empty.
    logic [AW:0] wr_bin;
    logic [AW:0] wr_gray;
    logic [AW:0] wr_bin_next;
    logic [AW:0] rd_bin;
    logic [AW:0] rd_gray;
    logic [AW:0] rd_bin_next;

    // Read pointer seen from the write clock.
    logic [AW:0] rd_gray_meta;
    logic [AW:0] rd_gray_sync;
    // Write pointer seen from the read clock.
    logic [AW:0] wr_gray_meta;
    logic [AW:0] wr_gray_sync;

    logic do_push;
    logic do_pop;

    function automatic logic [AW:0] bin2gray(input logic [AW:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    ////////////////////
    // Write side
    ////////////////////

    // Room left unless the pointers are one lap apart.
    assign wr_ready    = (wr_gray != (rd_gray_sync ^ FULL_XOR));
    assign do_push     = wr_en && wr_ready;
    assign wr_bin_next = wr_bin + (AW + 1)'(do_push);

    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else begin
            wr_bin  <= wr_bin_next;
            wr_gray <= bin2gray(wr_bin_next);
        end
    end

    always_ff @(posedge wr_clk) begin
        if (do_push) begin
            mem[wr_bin[AW-1:0]] <= data_in;
        end
    end

    // Bring the read pointer over.
    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_gray_meta <= '0;
            rd_gray_sync <= '0;
        end else begin
            rd_gray_meta <= rd_gray;
            rd_gray_sync <= rd_gray_meta;
        end
    end

    ////////////////////
    // Read side
    ////////////////////

    // Data waits while the pointers differ.
    assign rd_ready    = (rd_gray != wr_gray_sync);
    assign do_pop      = rd_en && rd_ready;
    assign rd_bin_next = rd_bin + (AW + 1)'(do_pop);

    // Show-ahead, the head word is always on the output.
    assign data_out = mem[rd_bin[AW-1:0]];

    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else begin
            rd_bin  <= rd_bin_next;
            rd_gray <= bin2gray(rd_bin_next);
        end
    end

    // Bring the write pointer over.
    // A push becomes visible after two read clock edges.
    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_gray_meta <= '0;
            wr_gray_sync <= '0;
        end else begin
            wr_gray_meta <= wr_gray;
            wr_gray_sync <= wr_gray_meta;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // The writer respects the full flag.
    push_when_full: assert property (@(posedge wr_clk) disable iff (!arst_n)
        wr_en |-> wr_ready);

    // The reader respects the empty flag.
    pop_when_empty: assert property (@(posedge rd_clk) disable iff (!arst_n)
        rd_en |-> rd_ready);

endmodule

`default_nettype wire

// ==== design/spi_sub_engine.sv ====
// SPI mode 0 shift engine, sclk domain.
// Assembles MOSI words on rising edges and shifts MISO out on falling edges.
// Held in reset while ssn is high.
`default_nettype none

module spi_sub_engine
    import spi_link_pkg::*;
(
    input  wire   sclk,
    input  wire   arst_n,
    input  wire   ssn,
    input  wire   mosi,
    output logic  miso,

    // Receive FIFO write side.
    output word_t rx_word,
    output logic  rx_push,

    // Transmit FIFO read side, clocked on the falling sclk edge.
    input  wire word_t tx_head,
    input  wire   tx_avail,
    output logic  tx_pop,

    // Sent when no transmit word is queued.
    input  wire word_t fill_byte
);
    // Engine reset, system reset or not selected.
    logic eng_rst_n;

    // Receive state.
    logic [BIT_CNT_W-1:0] rx_cnt;
    logic [WORD_W-2:0]    rx_shift;

    // Transmit state.
    logic [BIT_CNT_W-1:0] tx_cnt;
    logic [WORD_W-2:0]    tx_shift;
    logic                 word_start;
    word_t                next_word;

    assign eng_rst_n = arst_n & ~ssn;

    ////////////////////
    // Receive
    ////////////////////

    // Bit counter, wraps at each word.
    always_ff @(posedge sclk or negedge eng_rst_n) begin
        if (!eng_rst_n) begin
            rx_cnt <= '0;
        end else begin
            rx_cnt <= rx_cnt + 1'b1;
        end
    end

    // Only the first seven bits need storage.
    // The eighth goes straight to the FIFO.
    always_ff @(posedge sclk) begin
        rx_shift <= {rx_shift[WORD_W-3:0], mosi};
    end

    // Push on the edge that samples the last bit.
    assign rx_push = (rx_cnt == BIT_CNT_W'(WORD_W - 1));
    assign rx_word = {rx_shift, mosi};

    ////////////////////
    // Transmit
    ////////////////////

    // Queued word if there is one, else the fill byte.
    assign next_word  = tx_avail ? tx_head : fill_byte;
    // Counter at zero means MISO shows the MSB of the next word.
    assign word_start = (tx_cnt == '0);

    always_ff @(negedge sclk or negedge eng_rst_n) begin
        if (!eng_rst_n) begin
            tx_cnt <= '0;
        end else begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

    // First falling edge of a word, load the remaining bits.
    // The MSB has already been sampled by then.
    always_ff @(negedge sclk) begin
        if (word_start) begin
            tx_shift <= next_word[WORD_W-2:0];
        end else begin
            tx_shift <= {tx_shift[WORD_W-3:0], 1'b0};
        end
    end

    // Pop together with the load.
    // No pops between frames, so sclk may toggle while ssn is high.
    assign tx_pop = ~ssn && word_start && tx_avail;

    // The MSB comes straight from the head before the first edge.
    // MISO stays low while not selected.
    always_comb begin
        if (ssn) begin
            miso = 1'b0;
        end else if (word_start) begin
            miso = next_word[WORD_W-1];
        end else begin
            miso = tx_shift[WORD_W-2];
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // A queued word stays available until the engine pops it.
    tx_avail_held: assert property (@(negedge sclk) disable iff (!eng_rst_n)
        $fell(tx_avail) |-> $past(tx_pop));

endmodule

`default_nettype wire

// ==== design/spi_sub_regs.sv ====
// Wishbone classic register block, sys_clk domain.
// Holds the fill byte, moves words to and from the FIFOs
// and tracks the SPI frame state.
`default_nettype none

module spi_sub_regs
    import spi_link_pkg::*, wb_regs_pkg::*;
(
    input  wire                 sys_clk,
    input  wire                 arst_n,

    // Wishbone classic.
    input  wire                 wb_cyc,
    input  wire                 wb_stb,
    input  wire                 wb_we,
    input  wire [WB_ADR_W-1:0]  wb_adr,
    input  wire [WB_DAT_W-1:0]  wb_dat_w,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                wb_ack,

    // Raw chip select from the pad.
    input  wire                 ssn,

    // Receive FIFO read side.
    input  wire word_t          rx_data,
    input  wire                 rx_ready,
    output logic                rx_pop,

    // Transmit FIFO write side.
    input  wire                 tx_ready,
    output word_t               tx_data,
    output logic                tx_push,

    // To the engine, changed only between frames.
    output word_t               fill_byte
);
    // CTRL reset value.
    localparam word_t FILL_RESET = 8'hFF;

    reg_addr_e addr;
    logic      req;
    logic      wr_req;
    logic      rd_req;

    // Chip select synchronizer.
    logic      ssn_meta;
    logic      ssn_sync;
    logic      active;
    logic      active_q;
    logic      frame_end;
    logic      frame_done;

    logic [WB_DAT_W-1:0] rd_word;

    ////////////////////
    // Bus handshake
    ////////////////////

    assign addr = reg_addr_e'(wb_adr);

    // A request is taken once, stb is still high during the ack cycle.
    assign req    = wb_cyc && wb_stb && !wb_ack;
    assign wr_req = req && wb_we;
    assign rd_req = req && !wb_we;

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    ////////////////////
    // FIFO strobes
    ////////////////////

    // Writes to a full transmit FIFO are dropped.
    assign tx_push = wr_req && (addr == REG_TXDATA) && tx_ready;
    assign tx_data = wb_dat_w[WORD_W-1:0];

    // Empty receive FIFO, nothing to pop.
    assign rx_pop = rd_req && (addr == REG_RXDATA) && rx_ready;

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            fill_byte <= FILL_RESET;
        end else if (wr_req && addr == REG_CTRL) begin
            fill_byte <= wb_dat_w[WORD_W-1:0];
        end
    end

    // Two flops on ssn, idle high.
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            ssn_meta <= 1'b1;
            ssn_sync <= 1'b1;
            active_q <= 1'b0;
        end else begin
            ssn_meta <= ssn;
            ssn_sync <= ssn_meta;
            active_q <= active;
        end
    end

    assign active    = ~ssn_sync;
    assign frame_end = active_q && !active;

    // Sticky frame done, a new frame end wins over the clear.
    always_ff @(posedge sys_clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_done <= 1'b0;
        end else if (frame_end) begin
            frame_done <= 1'b1;
        end else if (wr_req && addr == REG_STATUS && wb_dat_w[STAT_FRAME_DONE]) begin
            frame_done <= 1'b0;
        end
    end

    ////////////////////
    // Read data
    ////////////////////

    always_comb begin
        rd_word = '0;
        case (addr)
            REG_CTRL: begin
                rd_word[WORD_W-1:0] = fill_byte;
            end
            REG_STATUS: begin
                rd_word[STAT_RX_READY]   = rx_ready;
                rd_word[STAT_TX_READY]   = tx_ready;
                rd_word[STAT_ACTIVE]     = active;
                rd_word[STAT_FRAME_DONE] = frame_done;
            end
            REG_RXDATA: begin
                // Head word is valid only while rx_ready is high.
                if (rx_ready) begin
                    rd_word[WORD_W-1:0] = rx_data;
                end
            end
            default: begin
                // TXDATA reads as zero.
                rd_word = '0;
            end
        endcase
    end

    // Captured with the request, presented with the ack.
    always_ff @(posedge sys_clk) begin
        if (rd_req) begin
            wb_dat_r <= rd_word;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // The fill byte crosses to sclk unsynchronized, so it only changes between frames.
    ctrl_write_idle: assert property (@(posedge sys_clk) disable iff (!arst_n)
        (wr_req && addr == REG_CTRL) |-> !active);

endmodule

`default_nettype wire

// ==== design/spi_sub_top.sv ====
// SPI sub peripheral on a Wishbone classic bus.
// Register block in sys_clk, shift engine in sclk, two async FIFOs between.
// New transmit words reach the engine after two falling sclk edges,
// which may be given while ssn is still high.
`default_nettype none

module spi_sub_top
    import spi_link_pkg::*, wb_regs_pkg::*;
#(
    parameter int RX_DEPTH = 8,
    parameter int TX_DEPTH = 8
) (
    input  wire                 sys_clk,
    input  wire                 arst_n,

    // Wishbone classic.
    input  wire                 wb_cyc,
    input  wire                 wb_stb,
    input  wire                 wb_we,
    input  wire [WB_ADR_W-1:0]  wb_adr,
    input  wire [WB_DAT_W-1:0]  wb_dat_w,
    output logic [WB_DAT_W-1:0] wb_dat_r,
    output logic                wb_ack,

    // SPI pads.
    input  wire                 sclk,
    input  wire                 ssn,
    input  wire                 mosi,
    output logic                miso
);
    // Receive path.
    word_t rx_word;
    logic  rx_push;
    word_t rx_data;
    logic  rx_ready;
    logic  rx_pop;

    // Transmit path.
    word_t tx_data;
    logic  tx_push;
    logic  tx_ready;
    word_t tx_head;
    logic  tx_avail;
    logic  tx_pop;

    word_t fill_byte;
    // Transmit read side runs on falling sclk.
    logic  sclk_n;

    assign sclk_n = ~sclk;

    spi_sub_regs u_regs (
        .sys_clk   (sys_clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .ssn       (ssn),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready),
        .rx_pop    (rx_pop),
        .tx_ready  (tx_ready),
        .tx_data   (tx_data),
        .tx_push   (tx_push),
        .fill_byte (fill_byte)
    );

    spi_sub_engine u_engine (
        .sclk      (sclk),
        .arst_n    (arst_n),
        .ssn       (ssn),
        .mosi      (mosi),
        .miso      (miso),
        .rx_word   (rx_word),
        .rx_push   (rx_push),
        .tx_head   (tx_head),
        .tx_avail  (tx_avail),
        .tx_pop    (tx_pop),
        .fill_byte (fill_byte)
    );

    // Words arriving on a full receive FIFO are lost.
    async_fifo #(
        .WIDTH (WORD_W),
        .DEPTH (RX_DEPTH)
    ) u_rx_fifo (
        .arst_n   (arst_n),
        .wr_clk   (sclk),
        .wr_en    (rx_push),
        .data_in  (rx_word),
        .wr_ready (),
        .rd_clk   (sys_clk),
        .rd_en    (rx_pop),
        .data_out (rx_data),
        .rd_ready (rx_ready)
    );

    // System reset only, queued words survive between frames.
    async_fifo #(
        .WIDTH (WORD_W),
        .DEPTH (TX_DEPTH)
    ) u_tx_fifo (
        .arst_n   (arst_n),
        .wr_clk   (sys_clk),
        .wr_en    (tx_push),
        .data_in  (tx_data),
        .wr_ready (tx_ready),
        .rd_clk   (sclk_n),
        .rd_en    (tx_pop),
        .data_out (tx_head),
        .rd_ready (tx_avail)
    );

endmodule

`default_nettype wire

// ==== test/tb_spi_sub.sv ====
// Testbench for the SPI sub peripheral.
// Drives the Wishbone bus and a SPI mode 0 main, and checks the
// register map, receive path, transmit path, fill byte and frame flag.
`default_nettype none

module tb_spi_sub
    import spi_link_pkg::*, wb_regs_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // Half periods of the two clocks.
    localparam int SYS_HALF    = 4;
    localparam int SCLK_HALF   = 20;
    // Bounds for every wait loop.
    localparam int ACK_TIMEOUT = 16;
    localparam int POLL_LIMIT  = 32;
    // Fill byte used by the underrun and full queue tests.
    localparam word_t FILL_A5  = 8'hA5;

    logic                sys_clk;
    logic                arst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [WB_DAT_W-1:0] wb_dat_w;
    logic [WB_DAT_W-1:0] wb_dat_r;
    logic                wb_ack;
    logic                sclk;
    logic                ssn;
    logic                mosi;
    logic                miso;

    // Words the main sends, words it sampled, words queued for transmit.
    word_t  mosi_words [$];
    word_t  miso_words [$];
    word_t  tx_words [$];
    string  test_name;
    integer seed;

    // Receive FIFO holds a whole 9 word frame, it is read after the frame.
    spi_sub_top #(
        .RX_DEPTH (16),
        .TX_DEPTH (8)
    ) u_dut (
        .sys_clk  (sys_clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .sclk     (sclk),
        .ssn      (ssn),
        .mosi     (mosi),
        .miso     (miso)
    );

    initial begin
        sys_clk = 1'b0;
        forever begin
            #(SYS_HALF);
            sys_clk = ~sys_clk;
        end
    end

    ////////////////////
    // Checking
    ////////////////////

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_equal(input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error: %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
            stop_with_failure();
        end
    endtask

    // STATUS value built from the flag positions.
    function automatic logic [31:0] status_word(input logic rx, input logic tx,
                                                 input logic act, input logic done);
        logic [31:0] w;
        w = '0;
        w[STAT_RX_READY]   = rx;
        w[STAT_TX_READY]   = tx;
        w[STAT_ACTIVE]     = act;
        w[STAT_FRAME_DONE] = done;
        return w;
    endfunction

    ////////////////////
    // Wishbone driver
    ////////////////////

    // One classic cycle, request after a clock edge, ends when ack is seen.
    task automatic wb_access(input logic we, input reg_addr_e adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        @(posedge sys_clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        waited   = 0;
        do begin
            @(posedge sys_clk);
            #1;
            waited++;
        end while (!wb_ack && waited < ACK_TIMEOUT);
        assert (wb_ack) else begin
            $display("%s: no Wishbone ack within %0d cycles", test_name, ACK_TIMEOUT);
            stop_with_failure();
        end
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input reg_addr_e adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input reg_addr_e adr, output logic [31:0] rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    // Poll STATUS until a received word shows up.
    task automatic wait_rx_ready();
        logic [31:0] status;
        int polls;
        polls = 0;
        do begin
            wb_read(REG_STATUS, status);
            polls++;
        end while (!status[STAT_RX_READY] && polls < POLL_LIMIT);
        assert (status[STAT_RX_READY]) else begin
            $display("%s: no received word appeared in STATUS", test_name);
            stop_with_failure();
        end
    endtask

    // Pop received words until the FIFO reads empty.
    task automatic drain_rx();
        logic [31:0] status;
        logic [31:0] dummy;
        int polls;
        polls = 0;
        wb_read(REG_STATUS, status);
        while (status[STAT_RX_READY] && polls < POLL_LIMIT) begin
            wb_read(REG_RXDATA, dummy);
            wb_read(REG_STATUS, status);
            polls++;
        end
        assert (!status[STAT_RX_READY]) else begin
            $display("%s: receive FIFO did not run empty", test_name);
            stop_with_failure();
        end
    endtask

    ////////////////////
    // SPI main model
    ////////////////////

    // Mode 0 frame of n_words, MOSI from mosi_words or zero, MISO into miso_words.
    task automatic run_frame(input int n_words);
        word_t out_byte;
        word_t in_byte;
        int    w;
        int    b;
        miso_words.delete();
        @(posedge sys_clk);
        #1;
        // Falling edges with ssn high carry queued words into the sclk domain.
        repeat (3) begin
            #(SCLK_HALF);
            sclk = 1'b1;
            #(SCLK_HALF);
            sclk = 1'b0;
        end
        #(SCLK_HALF);
        ssn = 1'b0;
        for (w = 0; w < n_words; w++) begin
            out_byte = (w < mosi_words.size()) ? mosi_words[w] : '0;
            for (b = WORD_W - 1; b >= 0; b--) begin
                mosi = out_byte[b];
                #(SCLK_HALF);
                // MISO only moves on falling edges.
                in_byte[b] = miso;
                sclk = 1'b1;
                #(SCLK_HALF);
                sclk = 1'b0;
            end
            miso_words.push_back(in_byte);
        end
        #(SCLK_HALF);
        ssn  = 1'b1;
        mosi = 1'b0;
        // Let the synchronized ssn and the receive pointer settle.
        repeat (4) @(posedge sys_clk);
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset_values();
        logic [31:0] data;
        test_name = "reset_values";
        wb_read(REG_STATUS, data);
        check_equal(status_word(1'b0, 1'b1, 1'b0, 1'b0), data);
        wb_read(REG_CTRL, data);
        check_equal(32'hFF, data);
        check_equal(32'h0, 32'(miso));
    endtask

    task automatic test_receive();
        logic [31:0] data;
        logic [31:0] rnd;
        test_name = "receive";
        mosi_words.delete();
        repeat (4) begin
            rnd = $random(seed);
            mosi_words.push_back(rnd[WORD_W-1:0]);
        end
        run_frame(4);
        // Nothing queued, so the reset fill byte goes out.
        foreach (miso_words[i]) begin
            check_equal(32'hFF, 32'(miso_words[i]));
        end
        wait_rx_ready();
        foreach (mosi_words[i]) begin
            wb_read(REG_RXDATA, data);
            check_equal(32'(mosi_words[i]), data);
        end
        wb_read(REG_STATUS, data);
        check_equal(32'h0, 32'(data[STAT_RX_READY]));
        wb_read(REG_RXDATA, data);
        check_equal(32'h0, data);
        mosi_words.delete();
    endtask

    task automatic test_transmit();
        logic [31:0] rnd;
        test_name = "transmit";
        tx_words.delete();
        repeat (3) begin
            rnd = $random(seed);
            tx_words.push_back(rnd[WORD_W-1:0]);
            wb_write(REG_TXDATA, 32'(rnd[WORD_W-1:0]));
        end
        run_frame(3);
        foreach (tx_words[i]) begin
            check_equal(32'(tx_words[i]), 32'(miso_words[i]));
        end
        drain_rx();
    endtask

    task automatic test_underrun();
        logic [31:0] data;
        logic [31:0] rnd;
        test_name = "underrun";
        wb_write(REG_CTRL, 32'(FILL_A5));
        wb_read(REG_CTRL, data);
        check_equal(32'(FILL_A5), data);
        rnd = $random(seed);
        wb_write(REG_TXDATA, 32'(rnd[WORD_W-1:0]));
        run_frame(3);
        check_equal(32'(rnd[WORD_W-1:0]), 32'(miso_words[0]));
        check_equal(32'(FILL_A5), 32'(miso_words[1]));
        check_equal(32'(FILL_A5), 32'(miso_words[2]));
        drain_rx();
    endtask

    task automatic test_full_queue();
        logic [31:0] data;
        logic [31:0] rnd;
        test_name = "full_queue";
        // Start from a cleared frame flag.
        wb_write(REG_STATUS, 32'(1) << STAT_FRAME_DONE);
        wb_read(REG_STATUS, data);
        check_equal(32'h0, 32'(data[STAT_FRAME_DONE]));
        tx_words.delete();
        repeat (9) begin
            rnd = $random(seed);
            tx_words.push_back(rnd[WORD_W-1:0]);
            wb_write(REG_TXDATA, 32'(rnd[WORD_W-1:0]));
        end
        wb_read(REG_STATUS, data);
        check_equal(32'h0, 32'(data[STAT_TX_READY]));
        run_frame(9);
        // Eight words fit, the ninth write was dropped.
        for (int i = 0; i < 8; i++) begin
            check_equal(32'(tx_words[i]), 32'(miso_words[i]));
        end
        check_equal(32'(FILL_A5), 32'(miso_words[8]));
        drain_rx();
        wb_read(REG_STATUS, data);
        check_equal(32'h1, 32'(data[STAT_FRAME_DONE]));
        wb_write(REG_STATUS, 32'(1) << STAT_FRAME_DONE);
        wb_read(REG_STATUS, data);
        check_equal(32'h0, 32'(data[STAT_FRAME_DONE]));
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        arst_n    = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        sclk      = 1'b0;
        ssn       = 1'b1;
        mosi      = 1'b0;
        seed      = 1;
        test_name = "reset";
        repeat (10) @(posedge sys_clk);
        #1;
        arst_n = 1'b1;

        test_reset_values();
        test_receive();
        test_transmit();
        test_underrun();
        test_full_queue();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/spi_link_pkg.sv
design/wb_regs_pkg.sv
design/async_fifo.sv
design/spi_sub_engine.sv
design/spi_sub_regs.sv
design/spi_sub_top.sv
test/tb_spi_sub.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP      ?= tb_spi_sub
FILELIST ?= filelist.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed."; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "Simulation did not finish."; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
